// ==== rvDecodePkg.sv ====
`default_nettype none

package rvDecodePkg;

    // major opcodes
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

    localparam int FETCH_DEPTH_DEF = 4;
    localparam int OUT_DEPTH_DEF   = 4;
    localparam int FENCE_STALL_DEF = 8;
    localparam int DEC_SLOTS       = 1;  // decode register is a single slot

    typedef struct packed {
        logic [31:0] match;
        logic [31:0] mask;
    } encPair_t;

    localparam logic [31:0] MASK_R      = 32'hFE00707F;  // funct7, funct3 and opcode
    localparam logic [31:0] MASK_I      = 32'h0000707F;
    localparam logic [31:0] MASK_U      = 32'h0000007F;
    localparam logic [31:0] MASK_ALL    = 32'hFFFFFFFF;
    localparam logic [31:0] MASK_SFENCE = 32'hFE007FFF;

    localparam encPair_t ENC_FENCE      = '{32'h0000000F, MASK_I};
    localparam encPair_t ENC_FENCE_I    = '{32'h0000100F, MASK_I};
    localparam encPair_t ENC_SFENCE_VMA = '{32'h12000073, MASK_SFENCE};

    localparam int NUM_LEGAL = 50;
    localparam encPair_t LEGAL_ENC [NUM_LEGAL] = '{
        // add sub sll slt sltu xor srl sra or and
        '{32'h00000033, MASK_R}, '{32'h40000033, MASK_R}, '{32'h00001033, MASK_R},
        '{32'h00002033, MASK_R}, '{32'h00003033, MASK_R}, '{32'h00004033, MASK_R},
        '{32'h00005033, MASK_R}, '{32'h40005033, MASK_R}, '{32'h00006033, MASK_R},
        '{32'h00007033, MASK_R},
        // op-imm then the immediate shifts
        '{32'h00000013, MASK_I}, '{32'h00002013, MASK_I}, '{32'h00003013, MASK_I},
        '{32'h00004013, MASK_I}, '{32'h00006013, MASK_I}, '{32'h00007013, MASK_I},
        '{32'h00001013, MASK_R}, '{32'h00005013, MASK_R}, '{32'h40005013, MASK_R},
        // loads and stores
        '{32'h00000003, MASK_I}, '{32'h00001003, MASK_I}, '{32'h00002003, MASK_I},
        '{32'h00004003, MASK_I}, '{32'h00005003, MASK_I},
        '{32'h00000023, MASK_I}, '{32'h00001023, MASK_I}, '{32'h00002023, MASK_I},
        // branches
        '{32'h00000063, MASK_I}, '{32'h00001063, MASK_I}, '{32'h00004063, MASK_I},
        '{32'h00005063, MASK_I}, '{32'h00006063, MASK_I}, '{32'h00007063, MASK_I},
        '{32'h0000006F, MASK_U}, '{32'h00000067, MASK_I},  // jal jalr
        '{32'h00000037, MASK_U}, '{32'h00000017, MASK_U},  // lui auipc
        // zicsr
        '{32'h00001073, MASK_I}, '{32'h00002073, MASK_I}, '{32'h00003073, MASK_I},
        '{32'h00005073, MASK_I}, '{32'h00006073, MASK_I}, '{32'h00007073, MASK_I},
        // ecall ebreak mret wfi
        '{32'h00000073, MASK_ALL}, '{32'h00100073, MASK_ALL},
        '{32'h30200073, MASK_ALL}, '{32'h10500073, MASK_ALL},
        ENC_FENCE, ENC_FENCE_I, ENC_SFENCE_VMA
    };

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rView_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rdImmLo;  // rd, or imm[4:0] on stores
        logic [6:0]  opcode;
    } iView_t;

    typedef union packed {
        rView_t r;
        iView_t i;
    } instWord_u;

    typedef struct packed {
        instWord_u   inst;
        logic [31:0] pc;
    } fetchItem_t;

    typedef struct packed {
        instWord_u   inst;
        logic [31:0] pc;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic        illegal;
        logic        fence;
        logic        load;
        logic        store;
        logic        csr;
        logic        ecall;
    } decodedItem_t;

    function automatic logic encHit(logic [31:0] word, encPair_t enc);
        return (word & enc.mask) == enc.match;
    endfunction

endpackage

`default_nettype wire

// ==== stageLink.sv ====
`timescale 1ns/1ps
`default_nettype none

interface stageLink #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1   // receiver slots, i.e. initial credits
);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic             valid;
    payload_t         payload;
    logic             creditReturn;  // one pulse per freed slot
    logic [CNT_W-1:0] credits;       // sender's current count

    modport sender (
        output valid,
        output payload,
        input  creditReturn,
        output credits
    );

    modport receiver (
        input  valid,
        input  payload,
        output creditReturn,
        input  credits
    );

endinterface

`default_nettype wire

// ==== fetchBuffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetchBuffer #(
    parameter int FETCH_DEPTH = rvDecodePkg::FETCH_DEPTH_DEF
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    valid_i,
    input  rvDecodePkg::fetchItem_t item_i,
    output logic                    credit_o,
    stageLink.sender                toDec
);
    import rvDecodePkg::*;

    localparam int AW = (FETCH_DEPTH > 1) ? $clog2(FETCH_DEPTH) : 1;
    localparam int CW = $clog2(FETCH_DEPTH + 1);
    localparam int DW = $clog2(DEC_SLOTS + 1);
    localparam logic [AW-1:0] LAST_PTR = AW'(FETCH_DEPTH - 1);
    localparam logic [CW-1:0] FULL_CNT = CW'(FETCH_DEPTH);
    localparam logic [DW-1:0] DEC_INIT = DW'(DEC_SLOTS);

    fetchItem_t    mem [FETCH_DEPTH];
    logic [AW-1:0] wrPtr;
    logic [AW-1:0] rdPtr;
    logic [CW-1:0] count;
    logic [DW-1:0] decCred;
    logic          pop;

    assign pop = (count != '0) && (decCred != '0);

    assign toDec.valid   = pop;
    assign toDec.payload = mem[rdPtr];
    assign toDec.credits = decCred;
    assign credit_o      = pop;  // slot frees as its entry leaves

    always_ff @(posedge clk) begin
        if (valid_i) begin
            mem[wrPtr] <= item_i;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wrPtr   <= '0;
            rdPtr   <= '0;
            count   <= '0;
            decCred <= DEC_INIT;
        end else begin
            if (valid_i) begin
                wrPtr <= (wrPtr == LAST_PTR) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == LAST_PTR) ? '0 : rdPtr + 1'b1;
            end
            case ({valid_i, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            case ({pop, toDec.creditReturn})
                2'b10:   decCred <= decCred - 1'b1;  // spent on decode
                2'b01:   decCred <= decCred + 1'b1;
                default: ;
            endcase
        end
    end

    // fetcher has to wait for fetchCredit_o before refilling
    noWriteWhenFull: assert property (@(posedge clk) disable iff (rst)
        valid_i |-> count != FULL_CNT);

endmodule

`default_nettype wire

// ==== idStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module idStage #(
    parameter int OUT_DEPTH   = rvDecodePkg::OUT_DEPTH_DEF,
    parameter int FENCE_STALL = rvDecodePkg::FENCE_STALL_DEF
) (
    input  logic       clk,
    input  logic       rst,
    stageLink.receiver fromFetch,
    stageLink.sender   toDisp
);
    import rvDecodePkg::*;

    localparam int CW = $clog2(OUT_DEPTH + 1);
    localparam int SW = $clog2(FENCE_STALL + 2);
    localparam logic [CW-1:0] CRED_FULL  = CW'(OUT_DEPTH);
    localparam logic [SW-1:0] STALL_LOAD = SW'(FENCE_STALL);

    fetchItem_t    holdItem;
    logic          holdValid;
    logic [CW-1:0] dispCred;
    logic [SW-1:0] stallCnt;
    logic          dispDrained;
    logic          send;
    logic          isLegal;
    logic          isFence;
    decodedItem_t  decItem;

    assign dispDrained = (dispCred == CRED_FULL);
    assign send = holdValid && (dispCred != '0) && (stallCnt == '0);

    assign toDisp.valid           = send;
    assign toDisp.payload         = decItem;
    assign toDisp.credits         = dispCred;
    assign fromFetch.creditReturn = send;  // slot is free once the item moves on

    always_ff @(posedge clk) begin
        if (fromFetch.valid) begin
            holdItem <= fromFetch.payload;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            holdValid <= 1'b0;
            dispCred  <= CRED_FULL;
        end else begin
            if (fromFetch.valid) begin
                holdValid <= 1'b1;
            end else if (send) begin
                holdValid <= 1'b0;
            end
            case ({send, toDisp.creditReturn})
                2'b10:   dispCred <= dispCred - 1'b1;
                2'b01:   dispCred <= dispCred + 1'b1;
                default: ;
            endcase
        end
    end

    // fence hold-off, counts down only once dispatch has drained
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stallCnt <= '0;
        end else if (send && isFence) begin
            stallCnt <= STALL_LOAD;
        end else if ((stallCnt != '0) && dispDrained) begin
            stallCnt <= stallCnt - 1'b1;
        end
    end

    always_comb begin
        isLegal = 1'b0;
        for (int k = 0; k < NUM_LEGAL; k++) begin
            isLegal |= encHit(holdItem.inst, LEGAL_ENC[k]);
        end
    end

    assign isFence = encHit(holdItem.inst, ENC_FENCE)
                  || encHit(holdItem.inst, ENC_FENCE_I)
                  || encHit(holdItem.inst, ENC_SFENCE_VMA);

    always_comb begin
        decItem         = '0;  // class flags are filled in by dispatch
        decItem.inst    = holdItem.inst;
        decItem.pc      = holdItem.pc;
        decItem.rs1     = holdItem.inst.r.rs1;
        decItem.rd      = holdItem.inst.r.rd;
        decItem.illegal = !isLegal;
        decItem.fence   = isFence;
        if (holdItem.inst.r.opcode == OPC_SYSTEM) begin
            decItem.rs2 = 5'd0;  // csr field, not a register
        end else begin
            decItem.rs2 = holdItem.inst.r.rs2;
        end
    end

    noFetchWhenFull: assert property (@(posedge clk) disable iff (rst)
        fromFetch.valid |-> !holdValid);

    // fetch buffer credits plus our occupancy never exceed the one slot
    fetchCreditsKept: assert property (@(posedge clk) disable iff (rst)
        fromFetch.credits + holdValid <= DEC_SLOTS);

endmodule

`default_nettype wire

// ==== dispatchStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module dispatchStage #(
    parameter int OUT_DEPTH = rvDecodePkg::OUT_DEPTH_DEF
) (
    input  logic        clk,
    input  logic        rst,
    stageLink.receiver  fromDec,
    output logic        outValid_o,
    output logic [31:0] outInst_o,
    output logic [31:0] outPc_o,
    output logic [4:0]  outRs1_o,
    output logic [4:0]  outRs2_o,
    output logic [4:0]  outRd_o,
    output logic        outIllegal_o,
    output logic        outLoad_o,
    output logic        outStore_o,
    output logic        outCsr_o,
    output logic        outEcall_o,
    input  logic        outCredit_i
);
    import rvDecodePkg::*;

    localparam int AW = (OUT_DEPTH > 1) ? $clog2(OUT_DEPTH) : 1;
    localparam int CW = $clog2(OUT_DEPTH + 1);
    localparam logic [AW-1:0] LAST_PTR  = AW'(OUT_DEPTH - 1);
    localparam logic [CW-1:0] DEPTH_CNT = CW'(OUT_DEPTH);

    decodedItem_t  mem [OUT_DEPTH];
    decodedItem_t  inItem;
    decodedItem_t  outItem;
    instWord_u     word;
    logic [AW-1:0] wrPtr;
    logic [AW-1:0] rdPtr;
    logic [CW-1:0] count;
    logic [CW-1:0] execCred;
    logic          pop;

    assign word = fromDec.payload.inst;
    assign pop  = (count != '0) && (execCred != '0);
    assign fromDec.creditReturn = pop;

    always_comb begin
        inItem       = fromDec.payload;
        inItem.load  = (word.r.opcode == OPC_LOAD)
                    && (word.r.funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
        inItem.store = (word.r.opcode == OPC_STORE)
                    && (word.r.funct3 inside {3'b000, 3'b001, 3'b010});
        inItem.csr   = (word.i.opcode == OPC_SYSTEM)
                    && (word.i.funct3 != 3'b000) && (word.i.funct3 != 3'b100);
        // ecall is the all-zero system word
        inItem.ecall = (word.i.opcode == OPC_SYSTEM) && (word.i.funct3 == 3'b000)
                    && (word.i.imm == '0) && (word.i.rs1 == '0) && (word.i.rdImmLo == '0);
    end

    always_ff @(posedge clk) begin
        if (fromDec.valid) begin
            mem[wrPtr] <= inItem;
        end
        if (pop) begin
            outItem <= mem[rdPtr];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wrPtr      <= '0;
            rdPtr      <= '0;
            count      <= '0;
            execCred   <= DEPTH_CNT;
            outValid_o <= 1'b0;
        end else begin
            outValid_o <= pop;  // one pulse per item
            if (fromDec.valid) begin
                wrPtr <= (wrPtr == LAST_PTR) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == LAST_PTR) ? '0 : rdPtr + 1'b1;
            end
            case ({fromDec.valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            case ({pop, outCredit_i})
                2'b10:   execCred <= execCred - 1'b1;
                2'b01:   execCred <= execCred + 1'b1;
                default: ;
            endcase
        end
    end

    assign outInst_o    = outItem.inst;
    assign outPc_o      = outItem.pc;
    assign outRs1_o     = outItem.rs1;
    assign outRs2_o     = outItem.rs2;
    assign outRd_o      = outItem.rd;
    assign outIllegal_o = outItem.illegal;
    assign outLoad_o    = outItem.load;
    assign outStore_o   = outItem.store;
    assign outCsr_o     = outItem.csr;
    assign outEcall_o   = outItem.ecall;

    noDecodeWhenFull: assert property (@(posedge clk) disable iff (rst)
        fromDec.valid |-> count != DEPTH_CNT);

    decodeCreditsKept: assert property (@(posedge clk) disable iff (rst)
        fromDec.credits + count <= OUT_DEPTH);

    // classified on entry, checked at the far end of the queue
    loadStoreExclusive: assert property (@(posedge clk) disable iff (rst)
        outValid_o |-> !(outLoad_o && outStore_o));

endmodule

`default_nettype wire

// ==== decodeFrontEnd.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeFrontEnd #(
    parameter int FETCH_DEPTH = rvDecodePkg::FETCH_DEPTH_DEF,
    parameter int OUT_DEPTH   = rvDecodePkg::OUT_DEPTH_DEF,
    parameter int FENCE_STALL = rvDecodePkg::FENCE_STALL_DEF
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        fetchValid_i,
    input  logic [31:0] fetchInst_i,
    input  logic [31:0] fetchPc_i,
    output logic        fetchCredit_o,
    output logic        outValid_o,
    output logic [31:0] outInst_o,
    output logic [31:0] outPc_o,
    output logic [4:0]  outRs1_o,
    output logic [4:0]  outRs2_o,
    output logic [4:0]  outRd_o,
    output logic        outIllegal_o,
    output logic        outLoad_o,
    output logic        outStore_o,
    output logic        outCsr_o,
    output logic        outEcall_o,
    input  logic        outCredit_i
);
    import rvDecodePkg::*;

    fetchItem_t fetchItem;

    assign fetchItem.inst = fetchInst_i;
    assign fetchItem.pc   = fetchPc_i;

    stageLink #(.payload_t(fetchItem_t), .DEPTH(DEC_SLOTS)) decLink ();
    stageLink #(.payload_t(decodedItem_t), .DEPTH(OUT_DEPTH)) dispLink ();

    fetchBuffer #(
        .FETCH_DEPTH (FETCH_DEPTH)
    ) fetchBuf (
        .clk      (clk),
        .rst      (rst),
        .valid_i  (fetchValid_i),
        .item_i   (fetchItem),
        .credit_o (fetchCredit_o),
        .toDec    (decLink.sender)
    );

    idStage #(
        .OUT_DEPTH   (OUT_DEPTH),
        .FENCE_STALL (FENCE_STALL)
    ) idStg (
        .clk       (clk),
        .rst       (rst),
        .fromFetch (decLink.receiver),
        .toDisp    (dispLink.sender)
    );

    dispatchStage #(
        .OUT_DEPTH (OUT_DEPTH)
    ) dispStg (
        .clk          (clk),
        .rst          (rst),
        .fromDec      (dispLink.receiver),
        .outValid_o   (outValid_o),
        .outInst_o    (outInst_o),
        .outPc_o      (outPc_o),
        .outRs1_o     (outRs1_o),
        .outRs2_o     (outRs2_o),
        .outRd_o      (outRd_o),
        .outIllegal_o (outIllegal_o),
        .outLoad_o    (outLoad_o),
        .outStore_o   (outStore_o),
        .outCsr_o     (outCsr_o),
        .outEcall_o   (outEcall_o),
        .outCredit_i  (outCredit_i)
    );

endmodule

`default_nettype wire

// ==== decodeFrontEndTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeFrontEndTb;

    localparam int FETCH_DEPTH  = 4;
    localparam int OUT_DEPTH    = 4;
    localparam int FENCE_STALL  = 8;
    localparam int RESET_CYCLES = 16;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic        illegal;
        logic        load;
        logic        store;
        logic        csr;
        logic        ecall;
        logic        fence;
    } traceEntry_t;

    logic        clk;
    logic        rst;
    logic        fetchValid;
    logic [31:0] fetchInst;
    logic [31:0] fetchPc;
    logic        fetchCredit;
    logic        outValid;
    logic [31:0] outInst;
    logic [31:0] outPc;
    logic [4:0]  outRs1;
    logic [4:0]  outRs2;
    logic [4:0]  outRd;
    logic        outIllegal;
    logic        outLoad;
    logic        outStore;
    logic        outCsr;
    logic        outEcall;
    logic        outCredit;

    traceEntry_t trace[$];
    traceEntry_t expQ[$];
    int          feedIdx;
    int          received;
    int          fetchCredits;
    int          execOutstanding;  // items taken by execute whose credit is not yet back
    int          cycleCnt;
    int          fenceCycle;
    logic        fenceSeen;
    logic        traceLoaded;
    logic [15:0] lfsr;

    decodeFrontEnd #(
        .FETCH_DEPTH (FETCH_DEPTH),
        .OUT_DEPTH   (OUT_DEPTH),
        .FENCE_STALL (FENCE_STALL)
    ) DUT (
        .clk           (clk),
        .rst           (rst),
        .fetchValid_i  (fetchValid),
        .fetchInst_i   (fetchInst),
        .fetchPc_i     (fetchPc),
        .fetchCredit_o (fetchCredit),
        .outValid_o    (outValid),
        .outInst_o     (outInst),
        .outPc_o       (outPc),
        .outRs1_o      (outRs1),
        .outRs2_o      (outRs2),
        .outRd_o       (outRd),
        .outIllegal_o  (outIllegal),
        .outLoad_o     (outLoad),
        .outStore_o    (outStore),
        .outCsr_o      (outCsr),
        .outEcall_o    (outEcall),
        .outCredit_i   (outCredit)
    );

    always #4 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrStep(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic failRun(string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic reportValue(string field, logic [31:0] pc, logic [31:0] got,
                               logic [31:0] want);
        failRun($sformatf("FAILED at %0t: %s for pc %h is %h, expected %h",
                          $time, field, pc, got, want));
    endtask

    task automatic checkOutput();
        traceEntry_t e;
        assert (expQ.size() > 0) else failRun("an output appeared after the last instruction");
        e = expQ.pop_front();
        assert (execOutstanding < OUT_DEPTH)
            else failRun("an output appeared without an execute credit");
        execOutstanding++;
        if (fenceSeen) begin
            assert (cycleCnt - fenceCycle >= FENCE_STALL + 2)
                else failRun($sformatf("FAILED at %0t: output %0d cycles after a fence, need %0d",
                                       $time, cycleCnt - fenceCycle, FENCE_STALL + 2));
        end
        fenceSeen  = e.fence;
        fenceCycle = cycleCnt;
        assert (outPc == e.pc) else reportValue("pc", e.pc, outPc, e.pc);
        assert (outInst == e.inst) else reportValue("inst", e.pc, outInst, e.inst);
        assert (outRs1 == e.rs1) else reportValue("rs1", e.pc, outRs1, e.rs1);
        assert (outRs2 == e.rs2) else reportValue("rs2", e.pc, outRs2, e.rs2);
        assert (outRd == e.rd) else reportValue("rd", e.pc, outRd, e.rd);
        assert (outIllegal == e.illegal) else reportValue("illegal", e.pc, outIllegal, e.illegal);
        assert (outLoad == e.load) else reportValue("load", e.pc, outLoad, e.load);
        assert (outStore == e.store) else reportValue("store", e.pc, outStore, e.store);
        assert (outCsr == e.csr) else reportValue("csr", e.pc, outCsr, e.csr);
        assert (outEcall == e.ecall) else reportValue("ecall", e.pc, outEcall, e.ecall);
        received++;  // end of test waits on this count
    endtask

    always @(posedge clk) begin : driveAndCheck
        logic takeBit;
        if (rst) begin
            assert (!fetchCredit && !outValid) else failRun("DUT outputs active during reset");
        end else begin
            cycleCnt++;
            if (fetchCredit) begin
                fetchCredits++;
            end
            assert (fetchCredits <= FETCH_DEPTH)
                else failRun("fetch buffer returned more credits than it has slots");
            if (fetchCredits > 0 && feedIdx < trace.size()) begin
                fetchValid <= 1'b1;
                fetchInst  <= trace[feedIdx].inst;
                fetchPc    <= trace[feedIdx].pc;
                fetchCredits--;
                feedIdx++;
            end else begin
                fetchValid <= 1'b0;
            end
            if (outValid) begin
                checkOutput();
            end
            takeBit = lfsr[15];
            lfsr    = lfsrStep(lfsr);
            if (execOutstanding > 0 && takeBit) begin
                outCredit <= 1'b1;
                execOutstanding--;
            end else begin
                outCredit <= 1'b0;
            end
        end
    end

    initial begin : runTest
        int          fd;
        int          code;
        traceEntry_t e;
        logic [31:0] inst;
        logic [31:0] pc;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic        ill;
        logic        ld;
        logic        st;
        logic        cs;
        logic        ec;
        logic        fe;
        logic [8*256-1:0] skipLine;
        clk             = 1'b0;
        rst             = 1'b1;
        fetchValid      = 1'b0;
        fetchInst       = '0;
        fetchPc         = '0;
        outCredit       = 1'b0;
        feedIdx         = 0;
        received        = 0;
        fetchCredits    = FETCH_DEPTH;
        execOutstanding = 0;
        cycleCnt        = 0;
        fenceCycle      = 0;
        fenceSeen       = 1'b0;
        traceLoaded     = 1'b0;
        lfsr            = 16'd50;
        fd = $fopen("decodeTrace.txt", "r");
        if (fd == 0) begin
            failRun("could not open decodeTrace.txt");
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h",
                           inst, pc, rs1, rs2, rd, ill, ld, st, cs, ec, fe);
            if (code == 11) begin
                e = '{inst, pc, rs1, rs2, rd, ill, ld, st, cs, ec, fe};
                trace.push_back(e);
                expQ.push_back(e);
            end else if (code == 0) begin
                code = $fgets(skipLine, fd);  // comment line
            end else if (code > 0) begin
                failRun("a trace line holds too few columns");
            end else begin
                break;
            end
        end
        $fclose(fd);
        if (trace.size() == 0) begin
            failRun("the trace holds no instructions");
        end
        traceLoaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        wait (received == trace.size());
        if (fetchCredits == FETCH_DEPTH && expQ.size() == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            failRun("fetch credits were not all returned at the end");
        end
    end

    initial begin : watchdog
        wait (traceLoaded);
        repeat (RESET_CYCLES + trace.size() * (FENCE_STALL + 20)) @(posedge clk);
        failRun($sformatf("timed out with %0d of %0d instructions delivered",
                          received, trace.size()));
    end

endmodule

`default_nettype wire

// ==== decodeTrace.txt ====
# inst pc rs1 rs2 rd illegal load store csr ecall fence, all hex
# rs2 reads as zero for system opcodes
00500093 80000000 00 05 01 0 0 0 0 0 0
002081B3 80000004 01 02 03 0 0 0 0 0 0
40118233 80000008 03 01 04 0 0 0 0 0 0
00812283 8000000C 02 08 05 0 1 0 0 0 0
00512623 80000010 02 05 0C 0 0 1 0 0 0
0FF0000F 80000014 00 1F 00 0 0 0 0 0 1
00130313 80000018 06 01 06 0 0 0 0 0 0
341093F3 8000001C 01 00 07 0 0 0 1 0 0
30526473 80000020 04 00 08 0 0 0 1 0 0
00000073 80000024 00 00 00 0 0 0 0 1 0
00100073 80000028 00 00 00 0 0 0 0 0 0
00000000 8000002C 00 00 00 1 0 0 0 0 0
00053483 80000030 0A 00 09 1 0 0 0 0 0
FFF64583 80000034 0C 1F 0B 0 1 0 0 0 0
00D701A3 80000038 0E 0D 03 0 0 1 0 0 0
00113023 8000003C 02 01 00 1 0 0 0 0 0
0000100F 80000040 00 00 00 0 0 0 0 0 1
123457B7 80000044 08 03 0F 0 0 0 0 0 0
010000EF 80000048 00 10 01 0 0 0 0 0 0
00208463 8000004C 01 02 08 0 0 0 0 0 0
0020A463 80000050 01 02 08 1 0 0 0 0 0
00389813 80000054 11 03 10 0 0 0 0 0 0
02389813 80000058 11 03 10 1 0 0 0 0 0
4079D913 8000005C 13 07 12 0 0 0 0 0 0
30200073 80000060 00 00 00 0 0 0 0 0 0
12208073 80000064 01 00 00 0 0 0 0 0 1
10500073 80000068 00 00 00 0 0 0 0 0 0
3410C3F3 8000006C 01 00 07 1 0 0 0 0 0
016AFA33 80000070 15 16 14 0 0 0 0 0 0
FFFFFF97 80000074 1F 1F 1F 0 0 0 0 0 0

// ==== flist.f ====
rvDecodePkg.sv
stageLink.sv
fetchBuffer.sv
idStage.sv
dispatchStage.sv
decodeFrontEnd.sv
decodeFrontEndTb.sv

// ==== Bender.yml ====
package:
  name: decode_front_end

sources:
  - rvDecodePkg.sv
  - stageLink.sv
  - fetchBuffer.sv
  - idStage.sv
  - dispatchStage.sv
  - decodeFrontEnd.sv
  - target: simulation
    files:
      - decodeFrontEndTb.sv
